//--- Makefile
# Verilator flow for the reshape FIFO testbench
TOP := rubik_fifo_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): rubik_fifo.f $(wildcard hdl/*.sv bench/*.sv bench/*.svh)
	verilator --binary --timing --assert -j 0 -f rubik_fifo.f --top-module $(TOP) -Mdir obj_dir

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/rubik_fifo_tb_checks.svh
/*
 * Compare tasks and error counters for the reshape FIFO testbench.
 * Included inside the testbench module, after the package imports.
 */
`ifndef RUBIK_FIFO_TB_CHECKS_SVH
`define RUBIK_FIFO_TB_CHECKS_SVH

// totals for the closing line
int n_checks = 0;
int n_errors = 0;

// one data beat against its expected value
task automatic check_payload(input string name, input payload_t exp, input payload_t act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

// occupancy or beat totals
task automatic check_count(input string name, input count_t exp, input count_t act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

// single handshake flag
task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
        n_errors++;
        $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
    end
endtask

// anything that is not a value mismatch
task automatic report_error(input string msg);
    n_errors++;
    $display("Error at %0t: %s", $time, msg);
endtask

`endif

//--- bench/rubik_fifo_tb.sv
/*
 * Testbench for the 80 x 256 reshape data FIFO. Reads one test per line
 * from bench/rubik_fifo_tests.dat, streams random beats through the DUT
 * with random stalls, or fills it against depth or wr_limit and drains.
 * Every output beat is scored against a model queue.
 */
`timescale 1ns/1ps
`default_nettype none

module rubik_fifo_tb;
    import rubik_fifo_cfg_pkg::*;
    import rubik_fifo_bus_pkg::*;

    logic     nvdla_core_clk_mgated;
    logic     nvdla_core_rstn;
    logic     idata_pvld;
    logic     idata_prdy;
    payload_t idata_pd;
    count_t   wr_limit;
    logic     odata_pvld;
    logic     odata_prdy;
    payload_t odata_pd;

    integer   seed = 32'hf5fe8e16;
    payload_t model_q[$];      // beats accepted, not yet seen at the output
    int       t_kind[$];
    int       t_beats[$];
    int       t_limit[$];
    int       t_pstall[$];
    int       t_cstall[$];
    int       watch_cycles = 0;
    int       sent;
    int       recv;
    logic     in_rdy_q = 1'b0;  // outputs as seen at the last falling edge
    logic     out_vld_q = 1'b0;
    payload_t out_pd_q;

    `include "rubik_fifo_tb_checks.svh"

    rubik_fifo_top dut0 (
        .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
        .nvdla_core_rstn       (nvdla_core_rstn),
        .idata_pvld            (idata_pvld),
        .idata_prdy            (idata_prdy),
        .idata_pd              (idata_pd),
        .wr_limit              (wr_limit),
        .odata_pvld            (odata_pvld),
        .odata_prdy            (odata_prdy),
        .odata_pd              (odata_pd)
    );

    initial begin
        nvdla_core_clk_mgated = 1'b0;
        forever #20 nvdla_core_clk_mgated = ~nvdla_core_clk_mgated;
    end

    // ========================================================================
    // stimulus helpers
    // ========================================================================

    function automatic bit chance_go(input int stall_pct);
        int pct;
        // a full stall still lets one cycle in a hundred through
        pct = (stall_pct > 99) ? 99 : stall_pct;
        return (($random(seed) & 32'h7fff_ffff) % 100) >= pct;
    endfunction

    function automatic payload_t random_payload();
        payload_t p;
        for (int w = 0; w < fifo_width / 32; w++) begin
            p.data[w*32 +: 32] = $random(seed);
        end
        return p;
    endfunction

    task automatic load_tests(output bit ok);
        int    fd;
        int    total;
        int    f[5];
        string line;
        total = 0;
        fd = $fopen("bench/rubik_fifo_tests.dat", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // skip comment and blank lines
                if (line.len() > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]) == 5) begin
                        t_kind.push_back(f[0]);
                        t_beats.push_back(f[1]);
                        t_limit.push_back(f[2]);
                        t_pstall.push_back(f[3]);
                        t_cstall.push_back(f[4]);
                        total += f[1] * 200;
                    end
                end
            end
            $fclose(fd);
        end
        ok = (t_kind.size() > 0);
        watch_cycles = total;
    endtask

    // one clock: score the last rising edge at the falling edge, resample
    task automatic cycle_score();
        payload_t exp;
        @(negedge nvdla_core_clk_mgated);
        if (idata_pvld && in_rdy_q) begin
            model_q.push_back(idata_pd);
            sent++;
            idata_pvld = 1'b0;
        end
        if (odata_prdy && out_vld_q) begin
            if (model_q.size() == 0) begin
                report_error("output beat arrived with the model queue empty");
            end else begin
                exp = model_q.pop_front();
                check_payload("odata_pd", exp, out_pd_q);
            end
            recv++;
        end else if (out_vld_q) begin
            // stalled beat must stay put
            check_flag("odata_pvld", 1'b1, odata_pvld);
            check_payload("odata_pd", out_pd_q, odata_pd);
        end
        in_rdy_q  = idata_prdy;
        out_vld_q = odata_pvld;
        out_pd_q  = odata_pd;
    endtask

    // new beat only once the previous one was taken
    task automatic offer_beat(input int beats, input int stall_pct);
        if (!idata_pvld && sent < beats && chance_go(stall_pct)) begin
            idata_pd   = random_payload();
            idata_pvld = 1'b1;
        end
    endtask

    // ========================================================================
    // test kinds
    // ========================================================================

    task automatic run_stream(input int beats, input int pstall, input int cstall);
        while (recv < beats) begin
            cycle_score();
            offer_beat(beats, pstall);
            odata_prdy = chance_go(cstall);
        end
    endtask

    task automatic run_fill(input int beats, input int limit, input int pstall,
                            input int cstall);
        int low_run;
        int base;
        low_run    = 0;
        odata_prdy = 1'b0;
        while (low_run < 16 && sent < beats) begin
            cycle_score();
            offer_beat(beats, pstall);
            low_run = in_rdy_q ? 0 : low_run + 1;
        end
        idata_pvld = 1'b0;
        // head beat left storage for the output register, outside the cap
        base = ((limit == 0) ? int'(fifo_depth) : limit) + 1;
        check_flag("odata_pvld", 1'b1, out_vld_q);
        // one more may sit in the input register
        if (sent == base + 1) begin
            check_count("accepted beats", count_t'(base + 1), count_t'(sent));
        end else begin
            check_count("accepted beats", count_t'(base), count_t'(sent));
        end
        while (recv < sent) begin
            cycle_score();
            odata_prdy = chance_go(cstall);
        end
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        bit ok;
        int errs_before;
        nvdla_core_rstn = 1'b0;
        idata_pvld      = 1'b0;
        idata_pd        = '0;
        wr_limit        = '0;
        odata_prdy      = 1'b0;
        load_tests(ok);
        repeat (10) @(posedge nvdla_core_clk_mgated);
        @(negedge nvdla_core_clk_mgated);
        nvdla_core_rstn = 1'b1;
        cycle_score();
        check_flag("idata_prdy", 1'b1, idata_prdy);
        check_flag("odata_pvld", 1'b0, odata_pvld);
        $display("test 0 reset: %s", (n_errors == 0) ? "ok" : "errors");
        if (!ok) begin
            report_error("no tests could be read from bench/rubik_fifo_tests.dat");
        end else begin
            for (int i = 0; i < t_kind.size(); i++) begin
                errs_before = n_errors;
                sent        = 0;
                recv        = 0;
                wr_limit    = count_t'(t_limit[i]);
                if (t_kind[i] == 1) begin
                    run_fill(t_beats[i], t_limit[i], t_pstall[i], t_cstall[i]);
                end else begin
                    run_stream(t_beats[i], t_pstall[i], t_cstall[i]);
                end
                // idle gap, catches stray output beats
                idata_pvld = 1'b0;
                odata_prdy = 1'b1;
                repeat (4) cycle_score();
                if (model_q.size() != 0) begin
                    report_error($sformatf("%0d beats never came out", model_q.size()));
                    model_q.delete();
                end
                $display("test %0d %s beats %0d limit %0d stalls %0d/%0d: %s", i + 1,
                         (t_kind[i] == 1) ? "fill" : "stream", sent, t_limit[i],
                         t_pstall[i], t_cstall[i],
                         (n_errors == errs_before) ? "ok" : "errors");
            end
        end
        $display("%0d tests, %0d checks, %0d errors", t_kind.size() + 1, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // budget of 200 cycles per beat over the whole file
    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge nvdla_core_clk_mgated);
        $display("timeout: tests still running after %0d cycles", watch_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/rubik_fifo_tests.dat
# kind beats limit pstall cstall  (stall columns in percent)
# kind 0 streams with random stalls, kind 1 fills with odata_prdy low, then drains
0 40 0 0 0
0 100 0 30 30
0 100 0 70 10
0 100 0 10 70
0 200 0 50 50
0 60 4 20 20
0 60 1 0 0
0 80 40 40 60
0 150 80 25 75
0 120 79 60 20
1 100 0 0 0
1 100 0 50 30
1 100 80 0 0
1 100 79 20 50
1 60 40 0 0
1 60 40 40 40
1 30 5 0 0
1 30 1 0 0
1 30 2 30 70
0 300 0 5 5
0 100 3 0 90
1 100 0 90 0
0 100 0 90 90
1 30 1 90 90
0 64 0 0 100
0 120 10 15 45
1 60 20 10 10
0 90 0 45 5

//--- hdl/rubik_fifo_bus_pkg.sv
/*
 * Bundles that move between the FIFO blocks: the data beat itself,
 * and the write and read requests into the storage array.
 */
`default_nettype none

package rubik_fifo_bus_pkg;

    // ========================================================================
    // payload
    // ========================================================================

    // one reshape beat, kept as a single field
    typedef struct packed {
        logic [rubik_fifo_cfg_pkg::fifo_width-1:0] data;
    } payload_t;

    // ========================================================================
    // storage requests
    // ========================================================================

    // write side -> storage, 264 bits
    typedef struct packed {
        logic                     en;    // write strobe
        rubik_fifo_cfg_pkg::ptr_t adr;   // slot to write
        payload_t                 data;  // registered input beat
    } ram_wr_t;

    // read side -> storage, 9 bits
    typedef struct packed {
        logic                     re;    // capture read address
        logic                     ore;   // load output register
        rubik_fifo_cfg_pkg::ptr_t adr;   // next head, or current when idle
    } ram_rd_t;

endpackage

`default_nettype wire

//--- hdl/rubik_fifo_cfg_pkg.sv
/*
 * Geometry of the reshape data FIFO: depth, width, index and count types.
 * Imported by every block that sizes a pointer or an occupancy value.
 */
`default_nettype none

package rubik_fifo_cfg_pkg;

    // storage shape
    localparam int unsigned fifo_depth = 80;
    localparam int unsigned fifo_width = 256;

    // index and occupancy widths
    localparam int unsigned ptr_w    = $clog2(fifo_depth);
    localparam int unsigned cnt_w    = $clog2(fifo_depth + 1);
    localparam int unsigned ptr_last = fifo_depth - 1;

    // memory index, wraps at ptr_last
    typedef logic [ptr_w-1:0] ptr_t;

    // occupancy 0..fifo_depth, also the write limit (0 = no limit)
    typedef logic [cnt_w-1:0] count_t;

    // next index around the ring
    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_t nxt;
        if (p == ptr_t'(ptr_last)) begin
            nxt = '0;
        end else begin
            nxt = p + 1'b1;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

//--- hdl/rubik_fifo_ram.sv
/*
 * Storage array of the reshape FIFO, 80 x 256. Synchronous write, read
 * address captured on re, and the head word loaded into an output
 * register on ore so the consumer sees it held while stalled.
 */
`timescale 1ns/1ps
`default_nettype none

module rubik_fifo_ram (
    input  logic                         nvdla_core_clk_mgated,
    input  rubik_fifo_bus_pkg::ram_wr_t  ram_wr,
    input  rubik_fifo_bus_pkg::ram_rd_t  ram_rd,
    output rubik_fifo_bus_pkg::payload_t dout
);
    import rubik_fifo_cfg_pkg::*;
    import rubik_fifo_bus_pkg::*;

    payload_t mem [fifo_depth];
    ptr_t     ra_d;             // captured read address

    // write port
    always_ff @(posedge nvdla_core_clk_mgated) begin
        if (ram_wr.en) begin
            mem[ram_wr.adr] <= ram_wr.data;
        end
    end

    // read address stage, pre-fetch slot
    always_ff @(posedge nvdla_core_clk_mgated) begin
        if (ram_rd.re) begin
            ra_d <= ram_rd.adr;
        end
    end

    // output register, held between pops
    always_ff @(posedge nvdla_core_clk_mgated) begin
        if (ram_rd.ore) begin
            dout <= mem[ra_d];
        end
    end

    // read side must wrap before the last slot
    a_rd_adr_range: assert property (@(posedge nvdla_core_clk_mgated)
        ram_rd.re |-> (ram_rd.adr < ptr_t'(fifo_depth)));

endmodule

`default_nettype wire

//--- hdl/rubik_fifo_rd_side.sv
/*
 * Read half of the reshape FIFO. Counts entries pushed by the write side,
 * pre-fetches the head address into the storage array, and presents the
 * head under odata_pvld, popping only when the output slot frees up.
 */
`timescale 1ns/1ps
`default_nettype none

module rubik_fifo_rd_side (
    input  logic                        nvdla_core_clk_mgated,
    input  logic                        nvdla_core_rstn,
    input  logic                        wr_push,
    input  logic                        odata_prdy,
    output logic                        odata_pvld,
    output rubik_fifo_bus_pkg::ram_rd_t ram_rd,
    output logic                        rd_pop
);
    import rubik_fifo_cfg_pkg::*;

    logic   rd_pushing;           // delayed wr_push
    logic   rd_popping;           // head moves to output this cycle
    logic   odata_pvld_p;         // pre-fetch slot holds the head
    logic   odata_pvld_int;       // output register valid
    logic   rd_enable;
    logic   rd_count_next_not_0;
    count_t rd_count;
    count_t rd_count_next;
    ptr_t   rd_adr;               // current head slot
    ptr_t   rd_adr_next;

    // ========================================================================
    // pop and occupancy
    // ========================================================================

    // pop when head is ready and output is empty or being taken
    assign rd_popping = odata_pvld_p && !(odata_pvld_int && !odata_prdy);

    always_comb begin
        case ({rd_pushing, rd_popping})
            2'b10:   rd_count_next = rd_count + 1'b1;
            2'b01:   rd_count_next = rd_count - 1'b1;
            default: rd_count_next = rd_count;
        endcase
    end

    assign rd_count_next_not_0 = (rd_count_next != '0);

    // fetch whenever data remains and the pre-fetch slot is free
    assign rd_enable = rd_count_next_not_0 && (!odata_pvld_p || rd_popping);

    assign rd_adr_next = ptr_inc(rd_adr);

    always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
        if (!nvdla_core_rstn) begin
            rd_pushing   <= 1'b0;
            rd_count     <= '0;
            odata_pvld_p <= 1'b0;
            rd_adr       <= '0;
        end else begin
            // let the write land in the array first
            rd_pushing <= wr_push;
            rd_count   <= rd_count_next;
            if (rd_pushing || rd_popping) begin
                odata_pvld_p <= rd_count_next_not_0;
            end
            if (rd_popping) begin
                rd_adr <= rd_adr_next;
            end
        end
    end

    // ========================================================================
    // output valid
    // ========================================================================

    always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
        if (!nvdla_core_rstn) begin
            odata_pvld_int <= 1'b0;
        end else begin
            // new head popped, or old one still waiting
            odata_pvld_int <= odata_pvld_p || (odata_pvld_int && !odata_prdy);
        end
    end

    assign odata_pvld = odata_pvld_int;
    assign rd_pop     = rd_popping;

    // next slot on a pop, otherwise re-read the current head
    assign ram_rd = '{re:  rd_enable,
                      ore: rd_popping,
                      adr: rd_popping ? rd_adr_next : rd_adr};

    // a stalled beat is never withdrawn and the head slot never moves under it
    a_stall_hold: assert property (@(posedge nvdla_core_clk_mgated)
        disable iff (!nvdla_core_rstn)
        (odata_pvld && !odata_prdy) |=> (odata_pvld && $stable(rd_adr)));

endmodule

`default_nettype wire

//--- hdl/rubik_fifo_top.sv
/*
 * Top of the 80 x 256 reshape data FIFO. Valid/ready on both sides, with
 * a run-time cap on occupancy through wr_limit (0 leaves the full depth).
 * Write side, storage array and read side, wired together here.
 */
`timescale 1ns/1ps
`default_nettype none

module rubik_fifo_top (
    input  logic                         nvdla_core_clk_mgated,
    input  logic                         nvdla_core_rstn,
    input  logic                         idata_pvld,
    output logic                         idata_prdy,
    input  rubik_fifo_bus_pkg::payload_t idata_pd,
    input  rubik_fifo_cfg_pkg::count_t   wr_limit,
    output logic                         odata_pvld,
    input  logic                         odata_prdy,
    output rubik_fifo_bus_pkg::payload_t odata_pd
);

    rubik_fifo_bus_pkg::ram_wr_t ram_wr;   // write request into storage
    rubik_fifo_bus_pkg::ram_rd_t ram_rd;   // pre-fetch and output load
    logic                        wr_push;  // one per written entry
    logic                        rd_pop;   // one per removed entry

    // producer side, credits come back through rd_pop
    rubik_fifo_wr_side wr0 (
        .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
        .nvdla_core_rstn       (nvdla_core_rstn),
        .idata_pvld            (idata_pvld),
        .idata_prdy            (idata_prdy),
        .idata_pd              (idata_pd),
        .wr_limit              (wr_limit),
        .rd_pop                (rd_pop),
        .ram_wr                (ram_wr),
        .wr_push               (wr_push)
    );

    // output register drives odata_pd directly
    rubik_fifo_ram ram0 (
        .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
        .ram_wr                (ram_wr),
        .ram_rd                (ram_rd),
        .dout                  (odata_pd)
    );

    // consumer side
    rubik_fifo_rd_side rd0 (
        .nvdla_core_clk_mgated (nvdla_core_clk_mgated),
        .nvdla_core_rstn       (nvdla_core_rstn),
        .wr_push               (wr_push),
        .odata_prdy            (odata_prdy),
        .odata_pvld            (odata_pvld),
        .ram_rd                (ram_rd),
        .rd_pop                (rd_pop)
    );

endmodule

`default_nettype wire

//--- hdl/rubik_fifo_wr_side.sv
/*
 * Write half of the reshape FIFO. Registers the incoming beat, reserves a
 * slot per accepted beat, counts occupancy against depth and run-time
 * limit, and returns credits from the delayed read-side pops.
 */
`timescale 1ns/1ps
`default_nettype none

module rubik_fifo_wr_side (
    input  logic                         nvdla_core_clk_mgated,
    input  logic                         nvdla_core_rstn,
    input  logic                         idata_pvld,
    output logic                         idata_prdy,
    input  rubik_fifo_bus_pkg::payload_t idata_pd,
    input  rubik_fifo_cfg_pkg::count_t   wr_limit,
    input  logic                         rd_pop,
    output rubik_fifo_bus_pkg::ram_wr_t  ram_wr,
    output logic                         wr_push
);
    import rubik_fifo_cfg_pkg::*;
    import rubik_fifo_bus_pkg::*;

    logic     idata_pvld_in;    // registered valid
    payload_t idata_pd_in;      // registered beat
    logic     wr_busy_in;       // input held this cycle
    logic     wr_busy_in_next;
    logic     wr_busy_in_int;   // beat waiting on space
    logic     idata_busy_int;   // no space this cycle
    logic     idata_busy_next;
    logic     wr_reserving;     // slot taken this cycle
    logic     wr_popping;       // credit back from read side
    count_t   wr_count;
    count_t   wr_count_next;
    ptr_t     wr_adr;

    // ========================================================================
    // input register
    // ========================================================================

    assign idata_prdy = !wr_busy_in;

    // a beat sits in the register with nowhere to go
    assign wr_busy_in_int = idata_pvld_in && idata_busy_int;

    // stay busy only if a beat is left over and space is still short
    assign wr_busy_in_next = idata_pvld ? idata_busy_next
                                        : (idata_pvld_in && idata_busy_next && !wr_reserving);

    always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
        if (!nvdla_core_rstn) begin
            idata_pvld_in <= 1'b0;
            wr_busy_in    <= 1'b0;
        end else begin
            wr_busy_in <= wr_busy_in_next;
            // keep a stranded beat until space frees up
            if (!wr_busy_in_int) begin
                idata_pvld_in <= idata_pvld && !wr_busy_in;
            end
        end
    end

    always_ff @(posedge nvdla_core_clk_mgated) begin
        if (idata_pvld && !wr_busy_in) begin
            idata_pd_in <= idata_pd;
        end
    end

    // ========================================================================
    // occupancy and busy
    // ========================================================================

    assign wr_reserving = idata_pvld_in && !idata_busy_int;

    always_comb begin
        case ({wr_reserving, wr_popping})
            2'b10:   wr_count_next = wr_count + 1'b1;
            2'b01:   wr_count_next = wr_count - 1'b1;
            default: wr_count_next = wr_count;
        endcase
    end

    // full at depth, or at the limit when one is set
    assign idata_busy_next = (wr_count_next == count_t'(fifo_depth)) ||
                             ((wr_limit != '0) && (wr_count_next >= wr_limit));

    always_ff @(posedge nvdla_core_clk_mgated or negedge nvdla_core_rstn) begin
        if (!nvdla_core_rstn) begin
            idata_busy_int <= 1'b0;
            wr_count       <= '0;
            wr_popping     <= 1'b0;
            wr_adr         <= '0;
        end else begin
            idata_busy_int <= idata_busy_next;
            wr_count       <= wr_count_next;
            // pop seen one cycle late
            wr_popping     <= rd_pop;
            if (wr_reserving) begin
                wr_adr <= ptr_inc(wr_adr);
            end
        end
    end

    // write lands the cycle after acceptance
    assign ram_wr  = '{en: wr_reserving, adr: wr_adr, data: idata_pd_in};
    assign wr_push = wr_reserving;

    // credits from the read side never push the count past the array
    a_wr_count_max: assert property (@(posedge nvdla_core_clk_mgated)
        disable iff (!nvdla_core_rstn) wr_count <= count_t'(fifo_depth));

endmodule

`default_nettype wire

//--- rubik_fifo.f
+incdir+bench
hdl/rubik_fifo_cfg_pkg.sv
hdl/rubik_fifo_bus_pkg.sv
hdl/rubik_fifo_wr_side.sv
hdl/rubik_fifo_ram.sv
hdl/rubik_fifo_rd_side.sv
hdl/rubik_fifo_top.sv
bench/rubik_fifo_tb.sv
